//--- hw/mci_axi_sub_decode.sv
// MCI request decoder
`timescale 1ns/1ns

module mci_axi_sub_decode #(
    parameter int MCU_SRAM_SIZE_KB = 4,
    parameter int NUM_MBOX_USERS   = 5
) (
    input  logic                                 clk,
    input  logic                                 reset,
    // SoC side
    input  logic                                 soc_dv,
    input  mci_pkg::cif_req_t                    soc_req,
    output mci_pkg::cif_rsp_t                    soc_rsp,
    // Register block
    output logic                                 reg_dv,
    output mci_pkg::cif_req_t                    reg_req,
    input  mci_pkg::cif_rsp_t                    reg_rsp,
    // Mailbox 0
    output logic                                 mbox0_dv,
    output mci_pkg::cif_req_t                    mbox0_req,
    input  mci_pkg::cif_rsp_t                    mbox0_rsp,
    // Mailbox 1
    output logic                                 mbox1_dv,
    output mci_pkg::cif_req_t                    mbox1_req,
    input  mci_pkg::cif_rsp_t                    mbox1_rsp,
    // MCU SRAM
    output logic                                 sram_dv,
    output mci_pkg::cif_req_t                    sram_req,
    input  mci_pkg::cif_rsp_t                    sram_rsp,
    // Valid user lists from the register block
    input  logic [NUM_MBOX_USERS-1:0][7:0]       valid_mbox0_users,
    input  logic [NUM_MBOX_USERS-1:0][7:0]       valid_mbox1_users,
    // Privileged user straps
    input  logic [7:0]                           strap_mcu_lsu_user,
    input  logic [7:0]                           strap_mcu_ifu_user,
    input  logic [7:0]                           strap_soc_config_user,
    // Privilege flags for the current request
    output logic                                 axi_mcu_req,
    output logic                                 axi_mci_soc_config_req
);

    // Inclusive window ends
    localparam logic [31:0] REG_END_ADDR   = mci_pkg::MCI_REG_START_ADDR
                                           + mci_pkg::MCI_REG_SIZE_BYTES - 32'd1;
    localparam logic [31:0] MBOX0_END_ADDR = mci_pkg::MBOX0_START_ADDR
                                           + mci_pkg::MBOX_SIZE_BYTES - 32'd1;
    localparam logic [31:0] MBOX1_END_ADDR = mci_pkg::MBOX1_START_ADDR
                                           + mci_pkg::MBOX_SIZE_BYTES - 32'd1;
    localparam logic [31:0] SRAM_END_ADDR  = mci_pkg::MCU_SRAM_START_ADDR
                                           + 32'(MCU_SRAM_SIZE_KB) * 32'd1024 - 32'd1;

    mci_pkg::mci_target_e tgt;
    logic                 mcu_user_match;
    logic                 cfg_user_match;
    logic                 mbox0_user_ok;
    logic                 mbox1_user_ok;

    ////////////////////////////////////////////////////////////////////////////
    // Privileged user detection
    ////////////////////////////////////////////////////////////////////////////

    assign mcu_user_match = (soc_req.user == strap_mcu_lsu_user) |
                            (soc_req.user == strap_mcu_ifu_user);

    // All zeros disables the config user, all ones makes everyone config
    assign cfg_user_match = ((soc_req.user == strap_soc_config_user) &
                             (|strap_soc_config_user)) |
                            (&strap_soc_config_user);

    assign axi_mcu_req            = soc_dv & mcu_user_match;
    assign axi_mci_soc_config_req = soc_dv & cfg_user_match;

    // Mailbox user qualification
    always_comb begin
        mbox0_user_ok = 1'b0;
        mbox1_user_ok = 1'b0;
        for (int i = 0; i < NUM_MBOX_USERS; i++) begin
            mbox0_user_ok |= (soc_req.user == valid_mbox0_users[i]);
            mbox1_user_ok |= (soc_req.user == valid_mbox1_users[i]);
        end
        // Default user and MCU always pass
        mbox0_user_ok |= (soc_req.user == mci_pkg::MCI_DEF_MBOX_USER) | mcu_user_match;
        mbox1_user_ok |= (soc_req.user == mci_pkg::MCI_DEF_MBOX_USER) | mcu_user_match;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Address decode and steering
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        tgt = mci_pkg::TGT_NONE;
        if (soc_req.addr inside {[mci_pkg::MCI_REG_START_ADDR:REG_END_ADDR]}) begin
            tgt = mci_pkg::TGT_REG;
        end else if (soc_req.addr inside {[mci_pkg::MBOX0_START_ADDR:MBOX0_END_ADDR]}) begin
            // Unqualified user falls through to a miss
            if (mbox0_user_ok) tgt = mci_pkg::TGT_MBOX0;
        end else if (soc_req.addr inside {[mci_pkg::MBOX1_START_ADDR:MBOX1_END_ADDR]}) begin
            if (mbox1_user_ok) tgt = mci_pkg::TGT_MBOX1;
        end else if (soc_req.addr inside {[mci_pkg::MCU_SRAM_START_ADDR:SRAM_END_ADDR]}) begin
            tgt = mci_pkg::TGT_SRAM;
        end
    end

    // Only the selected target sees dv
    assign reg_dv   = soc_dv & (tgt == mci_pkg::TGT_REG);
    assign mbox0_dv = soc_dv & (tgt == mci_pkg::TGT_MBOX0);
    assign mbox1_dv = soc_dv & (tgt == mci_pkg::TGT_MBOX1);
    assign sram_dv  = soc_dv & (tgt == mci_pkg::TGT_SRAM);

    // Request payload goes to everyone
    assign reg_req   = soc_req;
    assign mbox0_req = soc_req;
    assign mbox1_req = soc_req;
    assign sram_req  = soc_req;

    // Response mux, miss answers error with zero data
    always_comb begin
        soc_rsp = '0;
        case (tgt)
            mci_pkg::TGT_REG:   soc_rsp = reg_rsp;
            mci_pkg::TGT_MBOX0: soc_rsp = mbox0_rsp;
            mci_pkg::TGT_MBOX1: soc_rsp = mbox1_rsp;
            mci_pkg::TGT_SRAM:  soc_rsp = sram_rsp;
            default:            soc_rsp.error = soc_dv;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////////////////////////////////////////

    // At most one target per request
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({reg_dv, mbox0_dv, mbox1_dv, sram_dv}));

    // Targets only stall an active request
    assert property (@(posedge clk) disable iff (reset)
        soc_rsp.hold |-> soc_dv);

endmodule

//--- hw/mci_mbox_sram.sv
// Mailbox word memory
`timescale 1ns/1ns

module mci_mbox_sram #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              dv,
    input  mci_pkg::cif_req_t req,
    output mci_pkg::cif_rsp_t rsp
);

    localparam int AW = $clog2(DEPTH_WORDS);

    logic [31:0]   mem [DEPTH_WORDS];
    logic [AW-1:0] word_idx;

    // Byte address to word index, upper bits already decoded
    assign word_idx = req.addr[AW+1:2];

    // Zero wait state read straight from the array
    always_comb begin
        rsp       = '0;
        rsp.rdata = mem[word_idx];
    end

    // Writes land at the edge that completes the transfer
    always_ff @(posedge clk) begin
        if (dv && req.write && !reset) begin
            mem[word_idx] <= req.wdata;
        end
    end

endmodule

//--- hw/mci_pkg.sv
// MCI shared types and address map
package mci_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Request and response payloads
    ////////////////////////////////////////////////////////////////////////////

    // Word request from the SoC side
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [7:0]  user;
        logic        write;
    } cif_req_t;

    // Target response, read data valid when hold is low
    typedef struct packed {
        logic [31:0] rdata;
        logic        hold;
        logic        error;
    } cif_rsp_t;

    // Decode outcome for one request
    typedef enum logic [2:0] {
        TGT_NONE,
        TGT_REG,
        TGT_MBOX0,
        TGT_MBOX1,
        TGT_SRAM
    } mci_target_e;

    ////////////////////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////////////////////

    // Register window
    localparam logic [31:0] MCI_REG_START_ADDR  = 32'h0000_0000;
    localparam logic [31:0] MCI_REG_SIZE_BYTES  = 32'h0000_0100;

    // Mailbox windows, same size each
    localparam logic [31:0] MBOX0_START_ADDR    = 32'h0008_0000;
    localparam logic [31:0] MBOX1_START_ADDR    = 32'h0009_0000;
    localparam logic [31:0] MBOX_SIZE_BYTES     = 32'h0000_0400;

    // SRAM base, size comes from the top-level parameter
    localparam logic [31:0] MCU_SRAM_START_ADDR = 32'h0020_0000;

    // Always accepted by both mailboxes
    localparam logic [7:0]  MCI_DEF_MBOX_USER   = 8'hA5;

    // Fixed contents of the ID register
    localparam logic [31:0] MCI_ID_VALUE        = 32'h4D43_4901;

endpackage

//--- hw/mci_reg_block.sv
// MCI control registers
`timescale 1ns/1ns

module mci_reg_block #(
    parameter int NUM_MBOX_USERS = 5
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           dv,
    input  mci_pkg::cif_req_t              req,
    input  logic                           soc_config_req,
    output mci_pkg::cif_rsp_t              rsp,
    output logic [NUM_MBOX_USERS-1:0][7:0] valid_mbox0_users,
    output logic [NUM_MBOX_USERS-1:0][7:0] valid_mbox1_users
);

    // Word offsets within the register window
    localparam logic [5:0] ID_WORD      = 6'h00;
    localparam logic [5:0] SCRATCH_WORD = 6'h01;
    localparam int         MBOX0_WORD   = 16;
    localparam int         MBOX1_WORD   = 24;

    logic [5:0]                word_idx;
    logic                      wr_en;
    logic                      id_hit;
    logic                      scratch_hit;
    logic [NUM_MBOX_USERS-1:0] mbox0_hit;
    logic [NUM_MBOX_USERS-1:0] mbox1_hit;
    logic [31:0]               scratch_q;

    assign word_idx    = req.addr[7:2];
    assign wr_en       = dv & req.write;
    assign id_hit      = (word_idx == ID_WORD);
    assign scratch_hit = (word_idx == SCRATCH_WORD);

    always_comb begin
        for (int i = 0; i < NUM_MBOX_USERS; i++) begin
            mbox0_hit[i] = (word_idx == 6'(MBOX0_WORD + i));
            mbox1_hit[i] = (word_idx == 6'(MBOX1_WORD + i));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read data and error, never stalls
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rsp = '0;
        if (id_hit)      rsp.rdata = mci_pkg::MCI_ID_VALUE;
        if (scratch_hit) rsp.rdata = scratch_q;
        for (int i = 0; i < NUM_MBOX_USERS; i++) begin
            if (mbox0_hit[i]) rsp.rdata = {24'h0, valid_mbox0_users[i]};
            if (mbox1_hit[i]) rsp.rdata = {24'h0, valid_mbox1_users[i]};
        end
        // ID is read-only, user lists need the config user
        rsp.error = wr_en & (id_hit | ((|{mbox0_hit, mbox1_hit}) & ~soc_config_req));
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register updates
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            scratch_q         <= '0;
            valid_mbox0_users <= '0;
            valid_mbox1_users <= '0;
        end else if (wr_en) begin
            if (scratch_hit) scratch_q <= req.wdata;
            for (int i = 0; i < NUM_MBOX_USERS; i++) begin
                // Protected, dropped silently apart from the error
                if (mbox0_hit[i] && soc_config_req) valid_mbox0_users[i] <= req.wdata[7:0];
                if (mbox1_hit[i] && soc_config_req) valid_mbox1_users[i] <= req.wdata[7:0];
            end
        end
    end

endmodule

//--- hw/mci_top.sv
// MCI access subsystem top
`timescale 1ns/1ns

module mci_top #(
    parameter int MCU_SRAM_SIZE_KB = 4,
    parameter int NUM_MBOX_USERS   = 5
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              soc_dv,
    input  mci_pkg::cif_req_t soc_req,
    output mci_pkg::cif_rsp_t soc_rsp,
    input  logic [7:0]        strap_mcu_lsu_user,
    input  logic [7:0]        strap_mcu_ifu_user,
    input  logic [7:0]        strap_soc_config_user,
    output logic              axi_mcu_req,
    output logic              axi_mci_soc_config_req
);

    ////////////////////////////////////////////////////////////////////////////
    // Target side wiring
    ////////////////////////////////////////////////////////////////////////////

    logic                           reg_dv;
    mci_pkg::cif_req_t              reg_req;
    mci_pkg::cif_rsp_t              reg_rsp;
    logic                           mbox0_dv;
    mci_pkg::cif_req_t              mbox0_req;
    mci_pkg::cif_rsp_t              mbox0_rsp;
    logic                           mbox1_dv;
    mci_pkg::cif_req_t              mbox1_req;
    mci_pkg::cif_rsp_t              mbox1_rsp;
    logic                           sram_dv;
    mci_pkg::cif_req_t              sram_req;
    mci_pkg::cif_rsp_t              sram_rsp;
    logic [NUM_MBOX_USERS-1:0][7:0] valid_mbox0_users;
    logic [NUM_MBOX_USERS-1:0][7:0] valid_mbox1_users;

    // Decoder, also the privilege source for the register block
    mci_axi_sub_decode #(
        .MCU_SRAM_SIZE_KB (MCU_SRAM_SIZE_KB),
        .NUM_MBOX_USERS   (NUM_MBOX_USERS)
    ) u_decode (
        .clk                    (clk),
        .reset                  (reset),
        .soc_dv                 (soc_dv),
        .soc_req                (soc_req),
        .soc_rsp                (soc_rsp),
        .reg_dv                 (reg_dv),
        .reg_req                (reg_req),
        .reg_rsp                (reg_rsp),
        .mbox0_dv               (mbox0_dv),
        .mbox0_req              (mbox0_req),
        .mbox0_rsp              (mbox0_rsp),
        .mbox1_dv               (mbox1_dv),
        .mbox1_req              (mbox1_req),
        .mbox1_rsp              (mbox1_rsp),
        .sram_dv                (sram_dv),
        .sram_req               (sram_req),
        .sram_rsp               (sram_rsp),
        .valid_mbox0_users      (valid_mbox0_users),
        .valid_mbox1_users      (valid_mbox1_users),
        .strap_mcu_lsu_user     (strap_mcu_lsu_user),
        .strap_mcu_ifu_user     (strap_mcu_ifu_user),
        .strap_soc_config_user  (strap_soc_config_user),
        .axi_mcu_req            (axi_mcu_req),
        .axi_mci_soc_config_req (axi_mci_soc_config_req)
    );

    mci_reg_block #(
        .NUM_MBOX_USERS (NUM_MBOX_USERS)
    ) u_reg_block (
        .clk               (clk),
        .reset             (reset),
        .dv                (reg_dv),
        .req               (reg_req),
        .soc_config_req    (axi_mci_soc_config_req),
        .rsp               (reg_rsp),
        .valid_mbox0_users (valid_mbox0_users),
        .valid_mbox1_users (valid_mbox1_users)
    );

    // Two identical mailbox memories
    mci_mbox_sram #(.DEPTH_WORDS(256)) u_mbox0 (
        .clk   (clk),
        .reset (reset),
        .dv    (mbox0_dv),
        .req   (mbox0_req),
        .rsp   (mbox0_rsp)
    );

    mci_mbox_sram #(.DEPTH_WORDS(256)) u_mbox1 (
        .clk   (clk),
        .reset (reset),
        .dv    (mbox1_dv),
        .req   (mbox1_req),
        .rsp   (mbox1_rsp)
    );

    mcu_sram #(
        .MCU_SRAM_SIZE_KB (MCU_SRAM_SIZE_KB)
    ) u_mcu_sram (
        .clk   (clk),
        .reset (reset),
        .dv    (sram_dv),
        .req   (sram_req),
        .rsp   (sram_rsp)
    );

endmodule

//--- hw/mcu_sram.sv
// MCU SRAM with registered read
`timescale 1ns/1ns

module mcu_sram #(
    parameter int MCU_SRAM_SIZE_KB = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              dv,
    input  mci_pkg::cif_req_t req,
    output mci_pkg::cif_rsp_t rsp
);

    localparam int DEPTH_WORDS = MCU_SRAM_SIZE_KB * 256;
    localparam int AW          = $clog2(DEPTH_WORDS);

    typedef enum logic {
        SRAM_IDLE,
        SRAM_READ_WAIT
    } sram_state_e;

    sram_state_e   state;
    logic [31:0]   mem [DEPTH_WORDS];
    logic [31:0]   rdata_q;
    logic [AW-1:0] word_idx;
    logic          rd_start;

    assign word_idx = req.addr[AW+1:2];

    // New read seen in idle, stall one cycle
    assign rd_start = dv & ~req.write & (state == SRAM_IDLE);

    always_comb begin
        rsp       = '0;
        rsp.rdata = rdata_q;
        rsp.hold  = rd_start;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read state and array
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= SRAM_IDLE;
        end else if (rd_start) begin
            state <= SRAM_READ_WAIT;
        end else begin
            // Read completes out of the wait state
            state <= SRAM_IDLE;
        end
    end

    // Write completes with no stall
    always_ff @(posedge clk) begin
        if (rd_start) rdata_q <= mem[word_idx];
        if (dv && req.write && state == SRAM_IDLE) mem[word_idx] <= req.wdata;
    end

    // Exactly one wait state per read
    assert property (@(posedge clk) disable iff (reset)
        rsp.hold |=> !rsp.hold);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the MCI testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mci_tb -Mdir obj_dir -f vlog.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vmci_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0

//--- testbench/mci_tb.sv
// MCI subsystem testbench
`timescale 1ns/1ns

module mci_tb;

    localparam int          SRAM_KB     = 4;
    localparam int          NUM_USERS   = 5;
    localparam logic [31:0] SRAM_BYTES  = 32'(SRAM_KB * 1024);
    // Ample margin over roughly 450 cycles of transfers and reset
    localparam int          TIMEOUT_CYC = 4000;
    localparam logic [7:0]  MCU_LSU     = 8'h10;
    localparam logic [7:0]  MCU_IFU     = 8'h11;

    logic              clk;
    logic              reset;
    logic              soc_dv;
    mci_pkg::cif_req_t soc_req;
    mci_pkg::cif_rsp_t soc_rsp;
    logic [7:0]        strap_mcu_lsu_user;
    logic [7:0]        strap_mcu_ifu_user;
    logic [7:0]        strap_soc_config_user;
    logic              axi_mcu_req;
    logic              axi_mci_soc_config_req;

    // Shadow copies of DUT state
    logic [7:0]  cfg_strap;
    logic [31:0] scratch_m;
    logic [7:0]  users_m [2][NUM_USERS];
    logic [31:0] mbox_m [2][256];
    logic [31:0] sram_m [SRAM_KB*256];

    // Expectation for the transfer in flight
    mci_pkg::cif_rsp_t exp_rsp;
    logic              exp_check_data;
    logic              exp_mcu;
    logic              exp_cfg;
    int                exp_holds;
    int                hold_cnt;
    int                cycles;
    logic [31:0]       sram_addrs [$];

    mci_top #(
        .MCU_SRAM_SIZE_KB (SRAM_KB),
        .NUM_MBOX_USERS   (NUM_USERS)
    ) dut (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Failure handling and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "Run stopped at the first failed check");
    endtask

    task automatic compare_rsp(input string name, input mci_pkg::cif_rsp_t got,
                               input mci_pkg::cif_rsp_t exp, input logic check_data);
        if (got.error !== exp.error) begin
            abort_run($sformatf("[FAIL] %s.error addr 0x%h got 0x%h exp 0x%h",
                                name, soc_req.addr, got.error, exp.error));
        end else if (check_data && (got.rdata !== exp.rdata)) begin
            abort_run($sformatf("[FAIL] %s.rdata addr 0x%h got 0x%h exp 0x%h",
                                name, soc_req.addr, got.rdata, exp.rdata));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s user 0x%h got 0x%h exp 0x%h",
                                name, soc_req.user, got, exp));
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("[FAIL] %s addr 0x%h got 0x%h exp 0x%h",
                                name, soc_req.addr, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic is_mcu(input logic [7:0] user);
        return (user == MCU_LSU) || (user == MCU_IFU);
    endfunction

    // All-zero strap disables the config user
    // All-ones strap makes every user config
    function automatic logic is_cfg(input logic [7:0] user);
        return ((user == cfg_strap) && (cfg_strap != 8'h00)) || (cfg_strap == 8'hFF);
    endfunction

    function automatic logic mbox_user_ok(input int mb, input logic [7:0] user);
        logic ok;
        ok = (user == mci_pkg::MCI_DEF_MBOX_USER) || is_mcu(user);
        for (int i = 0; i < NUM_USERS; i++) begin
            if (users_m[mb][i] == user) ok = 1'b1;
        end
        return ok;
    endfunction

    function automatic logic in_window(input logic [31:0] a, input logic [31:0] base,
                                       input logic [31:0] size);
        return (a >= base) && ((a - base) < size);
    endfunction

    function automatic mci_pkg::mci_target_e ref_target(input mci_pkg::cif_req_t r);
        if (in_window(r.addr, mci_pkg::MCI_REG_START_ADDR, mci_pkg::MCI_REG_SIZE_BYTES))
            return mci_pkg::TGT_REG;
        if (in_window(r.addr, mci_pkg::MBOX0_START_ADDR, mci_pkg::MBOX_SIZE_BYTES))
            return mbox_user_ok(0, r.user) ? mci_pkg::TGT_MBOX0 : mci_pkg::TGT_NONE;
        if (in_window(r.addr, mci_pkg::MBOX1_START_ADDR, mci_pkg::MBOX_SIZE_BYTES))
            return mbox_user_ok(1, r.user) ? mci_pkg::TGT_MBOX1 : mci_pkg::TGT_NONE;
        if (in_window(r.addr, mci_pkg::MCU_SRAM_START_ADDR, SRAM_BYTES))
            return mci_pkg::TGT_SRAM;
        return mci_pkg::TGT_NONE;
    endfunction

    // Expected response from the shadow state before the request lands
    function automatic mci_pkg::cif_rsp_t ref_rsp(input mci_pkg::cif_req_t r);
        mci_pkg::cif_rsp_t rsp;
        int                w;
        logic              user_reg;
        rsp      = '0;
        w        = int'(r.addr[7:2]);
        user_reg = ((w >= 16) && (w < 16 + NUM_USERS)) || ((w >= 24) && (w < 24 + NUM_USERS));
        case (ref_target(r))
            mci_pkg::TGT_REG: begin
                if (w == 0) rsp.rdata = mci_pkg::MCI_ID_VALUE;
                else if (w == 1) rsp.rdata = scratch_m;
                else if (w >= 16 && w < 16 + NUM_USERS) rsp.rdata = {24'h0, users_m[0][w-16]};
                else if (w >= 24 && w < 24 + NUM_USERS) rsp.rdata = {24'h0, users_m[1][w-24]};
                rsp.error = r.write && ((w == 0) || (user_reg && !is_cfg(r.user)));
            end
            mci_pkg::TGT_MBOX0: rsp.rdata = mbox_m[0][r.addr[9:2]];
            mci_pkg::TGT_MBOX1: rsp.rdata = mbox_m[1][r.addr[9:2]];
            mci_pkg::TGT_SRAM:  rsp.rdata = sram_m[r.addr[11:2]];
            default:            rsp.error = 1'b1;
        endcase
        return rsp;
    endfunction

    // Successful writes only
    task automatic model_update(input mci_pkg::cif_req_t r, input mci_pkg::cif_rsp_t e);
        int w;
        w = int'(r.addr[7:2]);
        if (r.write && !e.error) begin
            case (ref_target(r))
                mci_pkg::TGT_REG: begin
                    if (w == 1) scratch_m = r.wdata;
                    if (w >= 16 && w < 16 + NUM_USERS) users_m[0][w-16] = r.wdata[7:0];
                    if (w >= 24 && w < 24 + NUM_USERS) users_m[1][w-24] = r.wdata[7:0];
                end
                mci_pkg::TGT_MBOX0: mbox_m[0][r.addr[9:2]] = r.wdata;
                mci_pkg::TGT_MBOX1: mbox_m[1][r.addr[9:2]] = r.wdata;
                mci_pkg::TGT_SRAM:  sram_m[r.addr[11:2]] = r.wdata;
                default: ;
            endcase
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Driver
    ////////////////////////////////////////////////////////////////////////////

    // Starts on a rising edge and returns on the completing edge
    task automatic transfer(input logic [31:0] addr, input logic write,
                            input logic [31:0] wdata, input logic [7:0] user);
        mci_pkg::cif_req_t r;
        mci_pkg::cif_rsp_t e;
        r.addr  = addr;
        r.wdata = wdata;
        r.user  = user;
        r.write = write;
        e       = ref_rsp(r);
        soc_dv         <= 1'b1;
        soc_req        <= r;
        exp_rsp        <= e;
        exp_check_data <= !write || (ref_target(r) == mci_pkg::TGT_NONE);
        exp_holds      <= ((ref_target(r) == mci_pkg::TGT_SRAM) && !write) ? 1 : 0;
        exp_mcu        <= is_mcu(user);
        exp_cfg        <= is_cfg(user);
        model_update(r, e);
        @(posedge clk);
        while (soc_rsp.hold) @(posedge clk);
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [7:0] user);
        transfer(addr, 1'b1, data, user);
    endtask

    task automatic read_word(input logic [31:0] addr, input logic [7:0] user);
        transfer(addr, 1'b0, 32'h0, user);
    endtask

    task automatic set_cfg_strap(input logic [7:0] v);
        cfg_strap = v;
        strap_soc_config_user <= v;
    endtask

    // Mostly privileged users with some random ones
    function automatic logic [7:0] pick_user();
        int sel;
        sel = int'($urandom % 4);
        if (sel == 0) return MCU_LSU;
        if (sel == 1) return MCU_IFU;
        if (sel == 2) return 8'h20;
        return 8'($urandom);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Compare process and timeout
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!reset && soc_dv) begin
            if (soc_rsp.hold) begin
                hold_cnt++;
            end else begin
                compare_rsp("soc_rsp", soc_rsp, exp_rsp, exp_check_data);
                compare_bit("axi_mcu_req", axi_mcu_req, exp_mcu);
                compare_bit("axi_mci_soc_config_req", axi_mci_soc_config_req, exp_cfg);
                compare_count("soc_rsp.hold cycles", hold_cnt, exp_holds);
                hold_cnt = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYC)
            abort_run("Timeout: the transfers did not finish within the cycle limit");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] a;
        void'($urandom(87708));
        hold_cnt  = 0;
        cycles    = 0;
        cfg_strap = 8'h20;
        scratch_m = '0;
        for (int i = 0; i < NUM_USERS; i++) begin
            users_m[0][i] = 8'h00;
            users_m[1][i] = 8'h00;
        end
        reset                 <= 1'b1;
        soc_dv                <= 1'b0;
        soc_req               <= '0;
        strap_mcu_lsu_user    <= MCU_LSU;
        strap_mcu_ifu_user    <= MCU_IFU;
        strap_soc_config_user <= 8'h20;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // ID, scratch and unmapped offset
        read_word(32'h0000_0000, 8'h01);
        write_word(32'h0000_0000, 32'h1234_5678, 8'h01);
        write_word(32'h0000_0004, 32'hDEAD_BEEF, 8'h01);
        read_word(32'h0000_0004, 8'h02);
        read_word(32'h0000_0080, 8'h01);

        // User list writes refused for others and accepted for the config user
        write_word(32'h0000_0040, 32'h0000_0033, 8'h33);
        read_word(32'h0000_0040, 8'h01);
        write_word(32'h0000_0040, 32'h0000_0033, 8'h20);
        write_word(32'h0000_0064, 32'h0000_0044, 8'h20);
        read_word(32'h0000_0040, 8'h01);
        read_word(32'h0000_0064, 8'h01);

        // Mailbox access control and separate contents
        write_word(mci_pkg::MBOX0_START_ADDR, 32'hA0A0_0000, 8'h33);
        write_word(mci_pkg::MBOX1_START_ADDR, 32'hB1B1_0000, 8'h44);
        write_word(mci_pkg::MBOX0_START_ADDR + 32'h4, 32'hA0A0_0004,
                   mci_pkg::MCI_DEF_MBOX_USER);
        write_word(mci_pkg::MBOX1_START_ADDR + 32'h4, 32'hB1B1_0004, MCU_LSU);
        write_word(mci_pkg::MBOX0_START_ADDR + 32'h3FC, 32'hA0A0_03FC, MCU_IFU);
        read_word(mci_pkg::MBOX0_START_ADDR, MCU_IFU);
        read_word(mci_pkg::MBOX1_START_ADDR, MCU_LSU);
        read_word(mci_pkg::MBOX0_START_ADDR + 32'h4, 8'h33);
        read_word(mci_pkg::MBOX1_START_ADDR + 32'h4, 8'h44);
        read_word(mci_pkg::MBOX0_START_ADDR + 32'h3FC, mci_pkg::MCI_DEF_MBOX_USER);
        write_word(mci_pkg::MBOX1_START_ADDR + 32'h8, 32'hBAD0_0008, 8'h33);
        read_word(mci_pkg::MBOX0_START_ADDR, 8'h77);

        // Random SRAM writes followed by read back
        for (int n = 0; n < 100; n++) begin
            a = mci_pkg::MCU_SRAM_START_ADDR + {20'h0, 10'($urandom), 2'b00};
            sram_addrs.push_back(a);
            write_word(a, $urandom, pick_user());
        end
        foreach (sram_addrs[n]) read_word(sram_addrs[n], pick_user());

        // Misses outside every window
        read_word(32'h0001_0000, 8'h01);
        write_word(32'h0001_0000, 32'h5555_AAAA, 8'h01);
        read_word(mci_pkg::MCU_SRAM_START_ADDR + SRAM_BYTES, MCU_LSU);
        read_word(mci_pkg::MBOX0_START_ADDR + mci_pkg::MBOX_SIZE_BYTES, 8'hA5);
        read_word(32'hFFFF_FFFC, 8'h20);

        // Privilege flags with random users
        for (int n = 0; n < 60; n++) begin
            a = ($urandom % 2 == 0) ? 32'h0000_0004 : mci_pkg::MBOX0_START_ADDR;
            read_word(a, pick_user());
        end

        // Everyone is config
        set_cfg_strap(8'hFF);
        write_word(32'h0000_0070, 32'h0000_0099, 8'h99);
        read_word(32'h0000_0070, 8'h01);
        for (int n = 0; n < 20; n++) read_word(32'h0000_0004, pick_user());

        // Nobody is config including a zero user
        set_cfg_strap(8'h00);
        write_word(32'h0000_0044, 32'h0000_0055, 8'h00);
        read_word(32'h0000_0044, 8'h00);
        for (int n = 0; n < 20; n++) read_word(32'h0000_0004, pick_user());

        soc_dv <= 1'b0;
        repeat (2) @(posedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- vlog.f
hw/mci_pkg.sv
hw/mci_axi_sub_decode.sv
hw/mci_reg_block.sv
hw/mci_mbox_sram.sv
hw/mcu_sram.sv
hw/mci_top.sv
testbench/mci_tb.sv
